/* hdl/hub_pkg.sv */
// repeating hub definitions

package hub_pkg;

  ////////////////////////////////////////////////////////////
  // sizing
  ////////////////////////////////////////////////////////////

  localparam int num_ports     = 3;
  localparam int ifg_cycles    = 10;
  localparam int max_pkt_bytes = 32;
  // room for two longest packets
  localparam int fifo_depth    = 64;
  localparam int desc_depth    = 2;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef logic [7:0] byte_t;
  typedef logic [5:0] pkt_len_t;
  typedef logic [1:0] port_id_t;
  typedef logic [$clog2(fifo_depth)-1:0] fifo_ptr_t;
  // pointer plus wrap bit, also used for fill levels
  typedef logic [$clog2(fifo_depth):0] fifo_cnt_t;

  // one byte slot on a port
  typedef struct packed {
    logic  vld;
    byte_t data;
  } byte_beat_t;

  typedef struct packed {
    logic     vld;
    port_id_t port;
  } grant_t;

  typedef enum logic [1:0] {
    tx_idle,
    tx_lead,
    tx_send,
    tx_gap
  } tx_state_t;

endpackage

/* hdl/frame_fifo.sv */
// packet byte store

`timescale 1ns/100ps

module frame_fifo import hub_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      wr_en,
  input  byte_t     wr_data,
  input  logic      commit,
  input  logic      rewind,
  input  logic      rd_en,
  output byte_t     rd_data,
  output fifo_cnt_t free_bytes
);

  // tentative write, committed write and read pointers
  fifo_cnt_t wr_ptr;
  fifo_cnt_t cm_ptr;
  fifo_cnt_t rd_ptr;
  byte_t     mem [fifo_depth];
  logic      rd_ok;

  // reader never passes the committed boundary
  assign rd_ok = rd_en && (rd_ptr != cm_ptr);

  // space left counts uncommitted bytes as used
  assign free_bytes = fifo_cnt_t'(fifo_depth) - (wr_ptr - rd_ptr);

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[fifo_ptr_t'(wr_ptr)] <= wr_data;
    end
    if (rd_ok) begin
      rd_data <= mem[fifo_ptr_t'(rd_ptr)];
    end
  end

  ////////////////////////////////////////////////////////////
  // pointers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      cm_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      // rewind throws away everything since the last commit
      if (rewind) begin
        wr_ptr <= cm_ptr;
      end else if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (commit) begin
        cm_ptr <= wr_ptr;
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

/* hdl/port_rx.sv */
// port receive framer

`timescale 1ns/100ps

module port_rx import hub_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  byte_beat_t rx,
  input  logic       desc_pop,
  input  logic       rd_en,
  output byte_t      rd_data,
  output logic       pend,
  output pkt_len_t   head_len
);

  logic      in_pkt;
  logic      dropped;
  pkt_len_t  len;
  pkt_len_t  cur_len;
  logic      cur_drop;
  logic      drop_now;
  logic      pkt_end;
  logic      commit;
  logic      rewind;
  logic      wr_en;
  fifo_cnt_t free_bytes;

  // length descriptor queue
  pkt_len_t                        desc_q [desc_depth];
  logic [$clog2(desc_depth)-1:0]   desc_wr;
  logic [$clog2(desc_depth)-1:0]   desc_rd;
  logic [$clog2(desc_depth):0]     desc_cnt;

  // first byte of a packet starts from a clean slate
  assign cur_len  = in_pkt ? len : '0;
  assign cur_drop = in_pkt ? dropped : 1'b0;

  // too long, or no byte left in the store
  assign drop_now = rx.vld && (cur_drop || cur_len == max_pkt_bytes || free_bytes == '0);
  assign wr_en    = rx.vld && !drop_now;

  assign pkt_end = in_pkt && !rx.vld;
  assign commit  = pkt_end && !dropped && (desc_cnt != desc_depth);
  assign rewind  = pkt_end && !commit;

  assign pend     = desc_cnt != '0;
  assign head_len = desc_q[desc_rd];

  frame_fifo fifo_i (
    .clk        (clk),
    .rst        (rst),
    .wr_en      (wr_en),
    .wr_data    (rx.data),
    .commit     (commit),
    .rewind     (rewind),
    .rd_en      (rd_en),
    .rd_data    (rd_data),
    .free_bytes (free_bytes)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      in_pkt  <= 1'b0;
      dropped <= 1'b0;
      len     <= '0;
    end else begin
      in_pkt  <= rx.vld;
      dropped <= rx.vld && drop_now;
      if (!rx.vld) begin
        len <= '0;
      end else if (wr_en) begin
        len <= cur_len + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (commit) begin
      desc_q[desc_wr] <= len;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      desc_wr  <= '0;
      desc_rd  <= '0;
      desc_cnt <= '0;
    end else begin
      if (commit) begin
        desc_wr <= desc_wr + 1'b1;
      end
      if (desc_pop) begin
        desc_rd <= desc_rd + 1'b1;
      end
      case ({commit, desc_pop})
        2'b10:   desc_cnt <= desc_cnt + 1'b1;
        2'b01:   desc_cnt <= desc_cnt - 1'b1;
        default: desc_cnt <= desc_cnt;
      endcase
    end
  end

endmodule

/* hdl/hub_sched.sv */
// round robin packet scheduler

`timescale 1ns/100ps

module hub_sched import hub_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [num_ports-1:0] pend,
  input  logic                 busy,
  output grant_t               grant
);

  port_id_t last;
  port_id_t pick;
  logic     found;
  logic     issue;

  // search starts one past the last served port
  always_comb begin
    int idx;
    pick  = last;
    found = 1'b0;
    for (int i = 1; i <= num_ports; i++) begin
      idx = (int'(last) + i) % num_ports;
      if (!found && pend[idx]) begin
        found = 1'b1;
        pick  = port_id_t'(idx);
      end
    end
  end

  // transmitter only reports busy one cycle after the grant,
  // so the grant pulse itself blocks a second one
  assign issue = found && !busy && !grant.vld;

  always_ff @(posedge clk) begin
    if (rst) begin
      grant <= '0;
      last  <= port_id_t'(num_ports - 1);
    end else begin
      grant.vld <= issue;
      if (issue) begin
        grant.port <= pick;
        last       <= pick;
      end
    end
  end

endmodule

/* hdl/port_tx.sv */
// packet transmit fan-out

`timescale 1ns/100ps

module port_tx import hub_pkg::*; (
  input  logic                             clk,
  input  logic                             rst,
  input  grant_t                           grant,
  input  pkt_len_t   [num_ports-1:0]       head_len,
  input  byte_t      [num_ports-1:0]       rd_data,
  output logic       [num_ports-1:0]       desc_pop,
  output logic       [num_ports-1:0]       rd_en,
  output logic                             busy,
  output byte_beat_t [num_ports-1:0]       tx_out
);

  typedef logic [$clog2(ifg_cycles+1)-1:0] gap_cnt_t;

  tx_state_t            state;
  port_id_t             src;
  pkt_len_t             cnt;
  gap_cnt_t             gap;
  logic [num_ports-1:0] src_hot;

  always_comb begin
    src_hot      = '0;
    src_hot[src] = 1'b1;
  end

  // one read ahead covers the fifo read latency
  assign rd_en = ((state == tx_lead) || (state == tx_send && cnt > 1)) ? src_hot : '0;
  assign busy  = state != tx_idle;

  ////////////////////////////////////////////////////////////
  // output fan-out
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int p = 0; p < num_ports; p++) begin
      tx_out[p].vld  = (state == tx_send) && (src != port_id_t'(p));
      tx_out[p].data = rd_data[src];
    end
  end

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= tx_idle;
      desc_pop <= '0;
      cnt      <= '0;
      gap      <= '0;
    end else begin
      desc_pop <= '0;
      case (state)
        tx_idle: begin
          if (grant.vld) begin
            src                  <= grant.port;
            cnt                  <= head_len[grant.port];
            desc_pop[grant.port] <= 1'b1;
            state                <= tx_lead;
          end
        end
        // first read in flight
        tx_lead: state <= tx_send;
        tx_send: begin
          cnt <= cnt - 1'b1;
          if (cnt == 1) begin
            gap   <= gap_cnt_t'(ifg_cycles);
            state <= tx_gap;
          end
        end
        tx_gap: begin
          gap <= gap - 1'b1;
          if (gap == 1) begin
            state <= tx_idle;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

endmodule

/* hdl/hub_top.sv */
// three port repeating hub

`timescale 1ns/100ps

module hub_top import hub_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  byte_beat_t [num_ports-1:0] rx_in,
  output byte_beat_t [num_ports-1:0] tx_out
);

  logic     [num_ports-1:0] pend;
  logic     [num_ports-1:0] desc_pop;
  logic     [num_ports-1:0] rd_en;
  pkt_len_t [num_ports-1:0] head_len;
  byte_t    [num_ports-1:0] rd_data;
  logic                     busy;
  grant_t                   grant;

  // receivers, one per port
  for (genvar p = 0; p < num_ports; p++) begin : g_rx
    port_rx rx_i (
      .clk      (clk),
      .rst      (rst),
      .rx       (rx_in[p]),
      .desc_pop (desc_pop[p]),
      .rd_en    (rd_en[p]),
      .rd_data  (rd_data[p]),
      .pend     (pend[p]),
      .head_len (head_len[p])
    );
  end

  hub_sched sched_i (
    .clk   (clk),
    .rst   (rst),
    .pend  (pend),
    .busy  (busy),
    .grant (grant)
  );

  port_tx tx_i (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .head_len (head_len),
    .rd_data  (rd_data),
    .desc_pop (desc_pop),
    .rd_en    (rd_en),
    .busy     (busy),
    .tx_out   (tx_out)
  );

endmodule

/* verif/hub_assert.sv */
// hub output protocol checks

`timescale 1ns/100ps

module hub_assert import hub_pkg::*; (
  input logic                       clk,
  input logic                       rst,
  input byte_beat_t [num_ports-1:0] tx_out
);

  logic [num_ports-1:0] vld;
  logic                 any_vld;
  int                   idle_cnt;

  always_comb begin
    for (int p = 0; p < num_ports; p++) begin
      vld[p] = tx_out[p].vld;
    end
  end

  assign any_vld = |vld;

  // idle cycles since the last output byte, saturating
  always_ff @(posedge clk) begin
    if (rst) begin
      idle_cnt <= ifg_cycles;
    end else if (any_vld) begin
      idle_cnt <= 0;
    end else if (idle_cnt < ifg_cycles) begin
      idle_cnt <= idle_cnt + 1;
    end
  end

  for (genvar p = 0; p < num_ports; p++) begin : g_port
    // no port joins a packet already under way
    a_src_quiet: assert property (@(posedge clk) disable iff (rst)
      $rose(vld[p]) |-> !$past(any_vld))
      else $error("tx_out[%0d] vld rose during a packet", p);

    for (genvar q = p + 1; q < num_ports; q++) begin : g_pair
      a_same_data: assert property (@(posedge clk) disable iff (rst)
        vld[p] && vld[q] |-> tx_out[p].data == tx_out[q].data)
        else $error("tx_out[%0d] and tx_out[%0d] carry different bytes", p, q);
    end
  end

  a_gap: assert property (@(posedge clk) disable iff (rst)
    $rose(any_vld) |-> idle_cnt >= ifg_cycles)
    else $error("packet started after only %0d idle cycles", idle_cnt);

endmodule

bind hub_top hub_assert assert_i (
  .clk    (clk),
  .rst    (rst),
  .tx_out (tx_out)
);

/* verif/hub_tb.sv */
// hub random packet testbench

`timescale 1ns/100ps

module hub_tb import hub_pkg::*; ();

  logic                       clk;
  logic                       rst;
  byte_beat_t [num_ports-1:0] rx_in;
  byte_beat_t [num_ports-1:0] tx_out;

  logic [31:0] rng = 32'h94832b42;
  int errors = 0;
  int gap_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int pkts_seen = 0;
  int cycles = 0;
  int cycle_limit = 1000;

  // stimulus per source, expected packets per output and source
  byte_t send_bytes [num_ports][$];
  int    send_len   [num_ports][$];
  byte_t exp_bytes  [num_ports][num_ports][$];
  int    exp_len    [num_ports][num_ports][$];
  int    started    [num_ports];
  int    delivered  [num_ports];

  // monitor state
  byte_t got     [num_ports][$];
  logic  in_run  [num_ports];
  int    run_src [num_ports];
  logic  in_burst = 1'b0;
  logic  seen_burst = 1'b0;
  int    idle_run = 0;

  hub_top dut_i (
    .clk    (clk),
    .rst    (rst),
    .rx_in  (rx_in),
    .tx_out (tx_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int pick(input int lo, input int hi);
    rng = xorshift(rng);
    return lo + int'(rng % (hi - lo + 1));
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus and reference model
  ////////////////////////////////////////////////////////////

  // legal packets are expected on every output but the source
  task automatic queue_packet(input int s, input int len);
    byte_t b;
    for (int i = 0; i < len; i++) begin
      b = byte_t'(pick(0, 255));
      send_bytes[s].push_back(b);
      for (int p = 0; p < num_ports; p++) begin
        if (p != s && len <= max_pkt_bytes) begin
          exp_bytes[p][s].push_back(b);
        end
      end
    end
    send_len[s].push_back(len);
    for (int p = 0; p < num_ports; p++) begin
      if (p != s && len <= max_pkt_bytes) begin
        exp_len[p][s].push_back(len);
      end
    end
    cycle_limit += (len + ifg_cycles + 10) * num_ports;
  endtask

  // a port waits until its last legal packet has come out
  task automatic run_traffic();
    int   left [num_ports];
    logic active;
    for (int s = 0; s < num_ports; s++) begin
      left[s] = 0;
    end
    active = 1'b1;
    while (active) begin
      @(negedge clk);
      active = 1'b0;
      for (int s = 0; s < num_ports; s++) begin
        if (left[s] > 0) begin
          rx_in[s].vld  = 1'b1;
          rx_in[s].data = send_bytes[s].pop_front();
          left[s]--;
        end else begin
          rx_in[s] = '0;
          if (send_len[s].size() > 0 && delivered[s] == started[s]) begin
            left[s] = send_len[s].pop_front();
            if (left[s] <= max_pkt_bytes) begin
              started[s]++;
            end
          end
        end
        if (left[s] > 0 || send_len[s].size() > 0 || delivered[s] != started[s]) begin
          active = 1'b1;
        end
      end
    end
    @(negedge clk);
    rx_in = '0;
    repeat (ifg_cycles + 4) @(negedge clk);
  endtask

  task automatic check_quiet();
    for (int p = 0; p < num_ports; p++) begin
      if (tx_out[p].vld !== 1'b0) begin
        $display("** Error at %0t: tx_out[%0d].vld = %b, expected 0", $time, p, tx_out[p].vld);
        errors++;
      end
    end
  endtask

  task automatic check_run(input int p);
    int    s;
    int    n;
    int    elen;
    byte_t e;
    s = run_src[p];
    n = got[p].size();
    pkts_seen++;
    if (exp_len[p][s].size() == 0) begin
      $display("tx_out[%0d] carried a %0d-byte packet from port %0d that was never sent",
               p, n, s);
      errors++;
    end else begin
      elen = exp_len[p][s].pop_front();
      if (n != elen) begin
        $display("** Error at %0t: tx_out[%0d] packet length = %0d, expected %0d",
                 $time, p, n, elen);
        errors++;
      end
      for (int i = 0; i < elen; i++) begin
        e = exp_bytes[p][s].pop_front();
        if (i < n && got[p][i] !== e) begin
          $display("** Error at %0t: tx_out[%0d].data byte %0d = %h, expected %h",
                   $time, p, i, got[p][i], e);
          errors++;
        end
      end
      // lowest other port stands for delivery of the packet
      if (p == (s == 0 ? 1 : 0)) begin
        delivered[s]++;
      end
    end
    got[p].delete();
  endtask

  task automatic log_result(input string name, input logic failed);
    tests_run++;
    if (failed) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    for (int p = 0; p < num_ports; p++) begin
      for (int s = 0; s < num_ports; s++) begin
        if (exp_len[p][s].size() != 0) begin
          $display("%0d packets from port %0d never reached tx_out[%0d]",
                   exp_len[p][s].size(), s, p);
          errors++;
          exp_len[p][s].delete();
          exp_bytes[p][s].delete();
        end
      end
    end
    log_result(name, errors != err_before);
  endtask

  ////////////////////////////////////////////////////////////
  // output monitor
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin : monitor
    int   lows;
    int   low_port;
    logic any_vld;
    lows     = 0;
    low_port = 0;
    any_vld  = 1'b0;
    if (!rst) begin
      for (int p = 0; p < num_ports; p++) begin
        if (tx_out[p].vld === 1'b1) begin
          any_vld = 1'b1;
        end else begin
          lows++;
          low_port = p;
        end
      end
      if (any_vld) begin
        if (!in_burst && seen_burst && idle_run < ifg_cycles) begin
          $display("** Error at %0t: idle cycles on tx_out = %0d, expected at least %0d",
                   $time, idle_run, ifg_cycles);
          errors++;
          gap_errors++;
        end
        if (!in_burst && lows != 1) begin
          $display("** Error at %0t: silent tx_out ports = %0d, expected 1", $time, lows);
          errors++;
        end
        in_burst = 1'b1;
        idle_run = 0;
      end else begin
        seen_burst = seen_burst | in_burst;
        in_burst   = 1'b0;
        idle_run++;
      end
      for (int p = 0; p < num_ports; p++) begin
        if (tx_out[p].vld === 1'b1) begin
          if (!in_run[p]) begin
            run_src[p] = low_port;
          end
          in_run[p] = 1'b1;
          got[p].push_back(tx_out[p].data);
        end else if (in_run[p]) begin
          in_run[p] = 1'b0;
          check_run(p);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: traffic still in flight after %0d cycles", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    int e0;
    int s_pick;
    int len_pick;
    rst   = 1'b1;
    rx_in = '0;
    for (int p = 0; p < num_ports; p++) begin
      in_run[p]    = 1'b0;
      started[p]   = 0;
      delivered[p] = 0;
    end

    e0 = errors;
    repeat (8) begin
      @(negedge clk);
      check_quiet();
    end
    rst = 1'b0;
    repeat (30) begin
      @(negedge clk);
      check_quiet();
    end
    if (pkts_seen != 0) begin
      $display("a packet appeared on tx_out without any input");
      errors++;
    end
    end_test("reset state", e0);

    e0 = errors;
    for (int s = 0; s < num_ports; s++) begin
      queue_packet(s, pick(1, max_pkt_bytes));
      run_traffic();
    end
    end_test("single packets", e0);

    e0 = errors;
    for (int s = 0; s < num_ports; s++) begin
      queue_packet(s, 1);
      queue_packet(s, max_pkt_bytes);
    end
    run_traffic();
    end_test("boundary lengths", e0);

    // oversize first, then a legal one from the same port
    e0 = errors;
    for (int s = 0; s < num_ports; s++) begin
      queue_packet(s, pick(max_pkt_bytes + 1, 40));
      queue_packet(s, pick(1, max_pkt_bytes));
    end
    run_traffic();
    end_test("oversize drop", e0);

    e0 = errors;
    repeat (60) begin
      s_pick   = pick(0, num_ports - 1);
      len_pick = pick(1, 40);
      queue_packet(s_pick, len_pick);
    end
    run_traffic();
    end_test("random traffic", e0);

    log_result("inter-frame gap", gap_errors != 0);

    $display("tests run %0d, failed %0d, errors %0d, packets checked %0d",
             tests_run, tests_failed, errors, pkts_seen);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* vlog.f */
hdl/hub_pkg.sv
hdl/frame_fifo.sv
hdl/port_rx.sv
hdl/hub_sched.sv
hdl/port_tx.sv
hdl/hub_top.sv
verif/hub_assert.sv
verif/hub_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the hub testbench with Verilator

set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module hub_tb -f vlog.f -o hub_sim \
  && ./obj_dir/hub_sim 2>&1 | tee sim.log \
  || { echo "simulation did not build or run to the end"; exit 1; }

grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0
